// File: hw/bp_cfg.svh
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// Address and history widths of a fetch request.
`define BP_ADDR_WIDTH   30
`define BP_HIST_WIDTH   16

// Table geometry, 256 entries.
`define BP_INDEX_WIDTH  8
`define BP_TAG_WIDTH    12

// FIFO depths and credit counts on both ports.
`define BP_IN_DEPTH     4
`define BP_OUT_DEPTH    4
`define BP_OUT_CREDITS  4

`endif

// File: hw/bp_pkg.sv
`include "bp_cfg.svh"

package bp_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch side.
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`BP_ADDR_WIDTH-1:0] pc;      // Word address of the fetch.
        logic [`BP_HIST_WIDTH-1:0] bh;      // Global branch history.
    } fetch_req_t;

    typedef struct packed {
        logic [`BP_ADDR_WIDTH-1:0] pc;
        logic [`BP_HIST_WIDTH-1:0] bh;
        logic [`BP_ADDR_WIDTH-1:0] target;  // Resolved branch target.
    } btb_update_t;

    ////////////////////////////////////////////////////////////////////////////
    // Table and result.
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                      valid;
        logic [`BP_TAG_WIDTH-1:0]  tag;
        logic [`BP_ADDR_WIDTH-1:0] target;
    } btb_entry_t;

    typedef enum logic [0:0] {
        src_fall_through = 1'b0,
        src_btb_hit      = 1'b1
    } pred_src_e;

    typedef struct packed {
        logic [`BP_ADDR_WIDTH-1:0] pc;
        logic [`BP_ADDR_WIDTH-1:0] npc;     // Predicted next fetch address.
        pred_src_e                 src;
    } prediction_t;

endpackage

// File: hw/btb_hash.sv
`timescale 1ns/100ps
`include "bp_cfg.svh"

module btb_hash (
    input  logic [`BP_ADDR_WIDTH-1:0]  pc,
    input  logic [`BP_HIST_WIDTH-1:0]  bh,
    output logic [`BP_INDEX_WIDTH-1:0] index,
    output logic [`BP_TAG_WIDTH-1:0]   tag
);

    // Bit i falls into slice i / width at position i % width, so xoring it
    // into position i % width folds all slices; a short last slice reads as
    // zero-extended.
    always_comb begin
        index = '0;
        for (int i = 0; i < `BP_ADDR_WIDTH; i++) begin
            index[i % `BP_INDEX_WIDTH] = index[i % `BP_INDEX_WIDTH] ^ pc[i];
        end
        for (int i = 0; i < `BP_HIST_WIDTH; i++) begin
            index[i % `BP_INDEX_WIDTH] = index[i % `BP_INDEX_WIDTH] ^ bh[i];
        end
    end

    // The tag depends on pc alone.
    always_comb begin
        tag = '0;
        for (int i = 0; i < `BP_ADDR_WIDTH; i++) begin
            tag[i % `BP_TAG_WIDTH] = tag[i % `BP_TAG_WIDTH] ^ pc[i];
        end
    end

endmodule

// File: hw/btb_ram.sv
`timescale 1ns/100ps
`include "bp_cfg.svh"

module btb_ram (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`BP_INDEX_WIDTH-1:0] raddr,
    output bp_pkg::btb_entry_t         rdata,
    input  logic                       we,
    input  logic [`BP_INDEX_WIDTH-1:0] waddr,
    input  bp_pkg::btb_entry_t         wdata
);

    localparam int DEPTH = 1 << `BP_INDEX_WIDTH;
    localparam int PW    = `BP_TAG_WIDTH + `BP_ADDR_WIDTH;

    logic [PW-1:0]    mem [DEPTH];
    logic [DEPTH-1:0] valid_bits;
    logic [PW-1:0]    rd_payload;
    logic             rd_valid;

    // Tag and target storage. Nonblocking update gives the old entry when a
    // read and a write hit the same index.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= {wdata.tag, wdata.target};
        end
        rd_payload <= mem[raddr];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            rd_valid   <= 1'b0;
        end else begin
            if (we) begin
                valid_bits[waddr] <= wdata.valid;
            end
            rd_valid <= valid_bits[raddr];         // Read-first like the payload.
        end
    end

    assign rdata.valid  = rd_valid;
    assign rdata.tag    = rd_payload[PW-1:`BP_ADDR_WIDTH];
    assign rdata.target = rd_payload[`BP_ADDR_WIDTH-1:0];

endmodule

// File: hw/btb.sv
`timescale 1ns/100ps
`include "bp_cfg.svh"

module btb (
    input  logic                clk,
    input  logic                reset,
    input  logic                lookup_valid,
    input  bp_pkg::fetch_req_t  lookup_req,
    input  logic                upd_valid,
    input  bp_pkg::btb_update_t upd,
    output logic                res_valid,
    output bp_pkg::prediction_t res
);

    logic [`BP_INDEX_WIDTH-1:0] q_index;
    logic [`BP_INDEX_WIDTH-1:0] u_index;
    logic [`BP_TAG_WIDTH-1:0]   q_tag;
    logic [`BP_TAG_WIDTH-1:0]   u_tag;
    logic [`BP_TAG_WIDTH-1:0]   tag_q;
    bp_pkg::fetch_req_t         req_q;
    logic                       lookup_q;
    bp_pkg::btb_entry_t         rd_entry;
    bp_pkg::btb_entry_t         wr_entry;
    logic                       hit;
    logic [`BP_ADDR_WIDTH-1:0]  fall_through;

    btb_hash u_query_hash (
        .pc    (lookup_req.pc),
        .bh    (lookup_req.bh),
        .index (q_index),
        .tag   (q_tag)
    );

    btb_hash u_update_hash (
        .pc    (upd.pc),
        .bh    (upd.bh),
        .index (u_index),
        .tag   (u_tag)
    );

    assign wr_entry = '{valid: 1'b1, tag: u_tag, target: upd.target};

    btb_ram u_ram (
        .clk   (clk),
        .reset (reset),
        .raddr (q_index),
        .rdata (rd_entry),
        .we    (upd_valid),
        .waddr (u_index),
        .wdata (wr_entry)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Request stage, in step with the synchronous table read.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            lookup_q <= 1'b0;
        end else begin
            lookup_q <= lookup_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            req_q <= lookup_req;
            tag_q <= q_tag;                          // Compared against the stored tag.
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result.
    ////////////////////////////////////////////////////////////////////////////

    assign hit          = rd_entry.valid && (rd_entry.tag == tag_q);
    assign fall_through = req_q.pc[0] ? req_q.pc + `BP_ADDR_WIDTH'(1)
                                      : req_q.pc + `BP_ADDR_WIDTH'(2);
    assign res_valid    = lookup_q;

    always_comb begin
        res.pc  = req_q.pc;
        res.npc = hit ? rd_entry.target : fall_through;
        res.src = hit ? bp_pkg::src_btb_hit : bp_pkg::src_fall_through;
    end

endmodule

// File: hw/fetch_req_buffer.sv
`timescale 1ns/100ps
`include "bp_cfg.svh"

module fetch_req_buffer (
    input  logic               clk,
    input  logic               reset,
    input  logic               req_valid,
    input  bp_pkg::fetch_req_t req,
    output logic               req_credit,
    input  logic               lookup_ready,
    output logic               lookup_valid,
    output bp_pkg::fetch_req_t lookup_req
);

    localparam int DEPTH = `BP_IN_DEPTH;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    bp_pkg::fetch_req_t mem [DEPTH];
    logic [PW-1:0]      wr_ptr;
    logic [PW-1:0]      rd_ptr;
    logic [CW-1:0]      count;
    logic               issue;

    function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // The requester holds a credit for every push, so there is always room.
    always_ff @(posedge clk) begin
        if (req_valid) begin
            mem[wr_ptr] <= req;
        end
    end

    assign issue        = (count != '0) && lookup_ready;
    assign lookup_valid = issue;
    assign lookup_req   = mem[rd_ptr];
    assign req_credit   = issue;                     // Slot frees as the head leaves.

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (issue) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({req_valid, issue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hw/pred_out_queue.sv
`timescale 1ns/100ps
`include "bp_cfg.svh"

module pred_out_queue (
    input  logic                clk,
    input  logic                reset,
    input  logic                res_valid,
    input  bp_pkg::prediction_t res,
    output logic                lookup_ready,
    input  logic                pred_credit,
    output logic                pred_valid,
    output bp_pkg::prediction_t pred
);

    localparam int DEPTH = `BP_OUT_DEPTH;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);
    localparam int KW    = $clog2(`BP_OUT_CREDITS + 1);

    bp_pkg::prediction_t mem [DEPTH];
    logic [PW-1:0]       wr_ptr;
    logic [PW-1:0]       rd_ptr;
    logic [CW-1:0]       count;
    logic [CW:0]         pending;
    logic [KW-1:0]       credit_cnt;
    logic                pop;

    function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Storage and slot reservation.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (res_valid) begin
            mem[wr_ptr] <= res;
        end
    end

    // A result in the lookup register already owns a slot.
    assign pending      = {1'b0, count} + {{CW{1'b0}}, res_valid};
    assign lookup_ready = pending < DEPTH;

    ////////////////////////////////////////////////////////////////////////////
    // Downstream side.
    ////////////////////////////////////////////////////////////////////////////

    assign pop        = (count != '0) && (credit_cnt != '0);
    assign pred_valid = pop;
    assign pred       = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_cnt <= KW'(`BP_OUT_CREDITS);
        end else begin
            if (res_valid) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({res_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({pred_credit, pop})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;   // Returned and spent together.
            endcase
        end
    end

endmodule

// File: hw/bp_top.sv
`timescale 1ns/100ps

module bp_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    input  bp_pkg::fetch_req_t  req,
    output logic                req_credit,
    input  logic                upd_valid,
    input  bp_pkg::btb_update_t upd,
    output logic                pred_valid,
    output bp_pkg::prediction_t pred,
    input  logic                pred_credit
);

    logic                lookup_valid;
    bp_pkg::fetch_req_t  lookup_req;
    logic                lookup_ready;
    logic                res_valid;
    bp_pkg::prediction_t res;

    fetch_req_buffer u_in (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req          (req),
        .req_credit   (req_credit),
        .lookup_ready (lookup_ready),
        .lookup_valid (lookup_valid),
        .lookup_req   (lookup_req)
    );

    btb u_btb (
        .clk          (clk),
        .reset        (reset),
        .lookup_valid (lookup_valid),
        .lookup_req   (lookup_req),
        .upd_valid    (upd_valid),
        .upd          (upd),
        .res_valid    (res_valid),
        .res          (res)
    );

    // Holds lookups back once the output side cannot take another result.
    pred_out_queue u_out (
        .clk          (clk),
        .reset        (reset),
        .res_valid    (res_valid),
        .res          (res),
        .lookup_ready (lookup_ready),
        .pred_credit  (pred_credit),
        .pred_valid   (pred_valid),
        .pred         (pred)
    );

endmodule

// File: verification/bp_tb.sv
`timescale 1ns/100ps
`include "bp_cfg.svh"

module bp_tb;

    localparam int          MAX_RECS = 64;
    localparam int          LIMIT    = 400;         // Cycles allowed for any one wait.
    localparam logic [31:0] SEED     = 32'h89a1a99c;

    logic                clk;
    logic                reset       = 1'b1;
    logic                req_valid   = 1'b0;
    bp_pkg::fetch_req_t  req         = '0;
    logic                req_credit;
    logic                upd_valid   = 1'b0;
    bp_pkg::btb_update_t upd         = '0;
    logic                pred_valid;
    bp_pkg::prediction_t pred;
    logic                pred_credit = 1'b0;

    logic [31:0]         vec [MAX_RECS * 5];    // Kind, pc, bh, value and hit per record.
    bp_pkg::prediction_t expect_q [$];
    int                  replay [$];
    logic [31:0]         rng_gap     = SEED;
    logic [31:0]         rng_credit  = SEED;
    int                  errors      = 0;
    int                  in_credits  = `BP_IN_DEPTH;
    int                  held        = `BP_OUT_CREDITS;   // Output credits the DUT may spend.
    int                  credit_odds = 12;
    int                  sent        = 0;
    int                  received    = 0;
    bit                  timed_out   = 1'b0;

    bp_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic step_or_expire(inout int waited, input string what);
        if (waited == LIMIT) begin
            $display("Timeout while waiting for %s", what);
            timed_out = 1'b1;
        end else begin
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Requester and credit return.
    ////////////////////////////////////////////////////////////////////////////

    task automatic wait_for_idle();
        int waited;
        waited = 0;
        while (expect_q.size() != 0 && !timed_out) begin
            step_or_expire(waited, "the outstanding predictions");
        end
    endtask

    task automatic send_query(input int rec, input int gap);
        int                  waited;
        bp_pkg::prediction_t exp_pred;
        waited = 0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        while (in_credits == 0 && !timed_out) begin
            step_or_expire(waited, "an input credit");
        end
        exp_pred.pc  = vec[rec*5+1][`BP_ADDR_WIDTH-1:0];
        exp_pred.npc = vec[rec*5+3][`BP_ADDR_WIDTH-1:0];
        exp_pred.src = vec[rec*5+4][0] ? bp_pkg::src_btb_hit : bp_pkg::src_fall_through;
        if (!timed_out) begin
            req_valid = 1'b1;
            req       = '{pc: exp_pred.pc, bh: vec[rec*5+2][`BP_HIST_WIDTH-1:0]};
            expect_q.push_back(exp_pred);
            in_credits--;                               // Spent on this request.
            sent++;
            @(posedge clk);
            #1;
            req_valid = 1'b0;
        end
    endtask

    // Output credits come back at random, never more than the DUT can hold.
    initial begin
        forever begin
            @(posedge clk);
            #1;
            rng_credit  = xorshift(rng_credit);
            pred_credit = !reset && held < `BP_OUT_CREDITS
                          && int'(rng_credit[15:12]) < credit_odds;
            if (pred_credit) begin
                held++;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Response checks, sampled mid-cycle.
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin : monitor
        bp_pkg::prediction_t head;
        if (!reset && req_credit) begin
            in_credits++;
        end
        if (!reset && pred_valid) begin
            received++;
            if (held - int'(pred_credit) == 0) begin   // A credit returned now counts next cycle.
                $display("pred_valid raised while the DUT held no output credit");
                errors++;
            end else begin
                held--;
            end
            if (expect_q.size() == 0) begin
                $display("Prediction for pc %h arrived with no query outstanding", pred.pc);
                errors++;
            end else begin
                head = expect_q.pop_front();            // Oldest query answers first.
                check_value("pred.pc", 32'(head.pc), 32'(pred.pc));
                check_value("pred.npc", 32'(head.npc), 32'(pred.npc));
                check_value("pred.src", 32'(head.src), 32'(pred.src));
            end
        end
    end

    initial begin : main
        int rec;
        $readmemh("verification/bp_vectors.txt", vec);
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // Updates wait until every earlier query has returned its prediction.
        rec = 0;
        while (rec < MAX_RECS && vec[rec*5] != 32'd0 && !timed_out) begin
            if (vec[rec*5] == 32'd1) begin
                wait_for_idle();
                upd_valid  = 1'b1;
                upd.pc     = vec[rec*5+1][`BP_ADDR_WIDTH-1:0];
                upd.bh     = vec[rec*5+2][`BP_HIST_WIDTH-1:0];
                upd.target = vec[rec*5+3][`BP_ADDR_WIDTH-1:0];
                @(posedge clk);
                #1;
                upd_valid = 1'b0;
                replay.delete();
            end else begin
                rng_gap = xorshift(rng_gap);
                send_query(rec, int'(rng_gap[1:0]));
                replay.push_back(rec);
            end
            rec++;
        end

        // The table no longer changes, so the last queries can be replayed in bursts.
        wait_for_idle();
        credit_odds = 3;
        for (int round = 0; round < 8; round++) begin
            foreach (replay[i]) begin
                send_query(replay[i], 0);
            end
        end
        wait_for_idle();

        check_value("in_credits", `BP_IN_DEPTH, 32'(in_credits));
        $display("Done: %0d errors, %0d queries, %0d predictions", errors, sent, received);
        if (errors == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: verification/bp_vectors.txt
// Columns are kind, pc, bh, value and hit.
// Kind 1 updates with value as target, kind 2 queries with value as expected npc, kind 0 ends.
2 00000101 0000 00000102 0
2 00000100 0000 00000102 0
2 3fffffff 0000 00000000 0
2 3ffffffe 0000 00000000 0
1 00001000 0000 00002468 0
2 00001000 0000 00002468 1
2 00000010 0000 00000012 0
2 00001000 0001 00001002 0
1 12345678 beef 0badf00d 0
2 12345678 beef 0badf00d 1
2 12345678 0000 1234567a 0
1 00001000 0000 0000abcd 0
2 00001000 0000 0000abcd 1
1 00000010 0000 00000555 0
2 00001000 0000 00001002 0
2 00000010 0000 00000555 1
2 12345678 beef 0badf00d 1
0 00000000 0000 00000000 0

// File: project.f
+incdir+hw
hw/bp_pkg.sv
hw/btb_hash.sv
hw/btb_ram.sv
hw/btb.sv
hw/fetch_req_buffer.sv
hw/pred_out_queue.sv
hw/bp_top.sv
verification/bp_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and searches the log for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module bp_tb -f project.f -Mdir obj_dir -o bp_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/bp_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

grep -qx "No errors" sim.log
